/* include/ooo_macros.svh */
// Core size macros
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Datapath width
`define OOO_XLEN 32

// Architectural register file
`define OOO_NUM_AREGS 32
`define OOO_AREG_W 5

// Reorder buffer depth is a power of two so the tags wrap
`define OOO_ROB_DEPTH 8
`define OOO_ROB_TAG_W 3

// Reservation-station slots with one ALU each
`define OOO_NUM_RS 4

`endif

/* hw/ooo_pkg.sv */
// Core type package
`include "ooo_macros.svh"

package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    // Operand, result and register value
    typedef logic [`OOO_XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [`OOO_AREG_W-1:0] areg_t;

    // Reorder-buffer entry index
    typedef logic [`OOO_ROB_TAG_W-1:0] rob_tag_t;

    // One bit per slot
    typedef logic [`OOO_NUM_RS-1:0] rs_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////////////////////////

    // ADDI takes source 2 from the immediate
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } alu_op_e;

endpackage

/* hw/rename_dispatch.sv */
// Rename and dispatch stage
`timescale 1ns/100ps
`include "ooo_macros.svh"

module rename_dispatch
    import ooo_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    // Decoded op in program order
    input  logic     in_valid,
    input  alu_op_e  in_op,
    input  areg_t    in_dest,
    input  areg_t    in_src1,
    input  areg_t    in_src2,
    input  word_t    in_imm,
    output logic     in_ready,
    // Slot allocation
    input  rs_mask_t slot_busy,
    output rs_mask_t alloc_mask,
    output alu_op_e  alloc_op,
    output word_t    alloc_v1,
    output word_t    alloc_v2,
    output logic     alloc_rdy1,
    output logic     alloc_rdy2,
    output rob_tag_t alloc_q1,
    output rob_tag_t alloc_q2,
    output rob_tag_t alloc_tag,
    // Reorder buffer side
    input  logic     rob_ready,
    input  rob_tag_t rob_tail,
    output rob_tag_t rob_rd1_tag,
    output rob_tag_t rob_rd2_tag,
    input  logic     rob_rd1_complete,
    input  word_t    rob_rd1_value,
    input  logic     rob_rd2_complete,
    input  word_t    rob_rd2_value,
    output logic     rob_alloc_en,
    output areg_t    rob_alloc_dest,
    // Result bus
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    // Retire write
    input  logic     retire_en,
    input  areg_t    retire_dest,
    input  rob_tag_t retire_tag,
    input  word_t    retire_value
);

    // Map table and architectural state
    logic [`OOO_NUM_AREGS-1:0] map_valid;
    rob_tag_t                  map_tag [`OOO_NUM_AREGS];
    word_t                     arf [`OOO_NUM_AREGS];

    rs_mask_t free_mask;
    logic     accept;
    word_t    src2_value;
    logic     src2_ready;

    // Operand lookup where the first match wins
    function automatic void resolve(
        input  areg_t    src,
        input  logic     mapped,
        input  rob_tag_t tag,
        input  word_t    arf_value,
        input  logic     rob_complete,
        input  word_t    rob_value,
        output word_t    value,
        output logic     ready
    );
        value = '0;
        ready = 1'b1;
        if (src == '0)
            value = '0;
        else if (!mapped)
            value = arf_value;
        else if (rob_complete)
            value = rob_value;
        // Producer broadcasting right now
        else if (cdb_valid && cdb_tag == tag)
            value = cdb_value;
        else
            ready = 1'b0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Slot pick and handshake
    //////////////////////////////////////////////////////////////////////

    // Lowest free slot, one-hot
    always_comb begin
        free_mask = '0;
        for (int i = 0; i < `OOO_NUM_RS; i++) begin
            if (!slot_busy[i] && free_mask == '0)
                free_mask[i] = 1'b1;
        end
    end

    assign in_ready = rob_ready && (free_mask != '0);
    assign accept   = in_valid && in_ready;

    assign alloc_mask     = accept ? free_mask : '0;
    assign alloc_op       = in_op;
    assign alloc_tag      = rob_tail;
    assign rob_alloc_en   = accept;
    assign rob_alloc_dest = in_dest;

    // Completed-entry reads by mapped tag
    assign rob_rd1_tag = map_tag[in_src1];
    assign rob_rd2_tag = map_tag[in_src2];
    assign alloc_q1    = map_tag[in_src1];
    assign alloc_q2    = map_tag[in_src2];

    always_comb begin
        resolve(in_src1, map_valid[in_src1], map_tag[in_src1], arf[in_src1],
                rob_rd1_complete, rob_rd1_value, alloc_v1, alloc_rdy1);
        resolve(in_src2, map_valid[in_src2], map_tag[in_src2], arf[in_src2],
                rob_rd2_complete, rob_rd2_value, src2_value, src2_ready);
        alloc_v2   = src2_value;
        alloc_rdy2 = src2_ready;
        // Immediate replaces source 2
        if (in_op == OP_ADDI) begin
            alloc_v2   = in_imm;
            alloc_rdy2 = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Map and register file update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            map_valid <= '0;
            arf       <= '{default: '0};
        end else begin
            if (retire_en && retire_dest != '0)
                arf[retire_dest] <= retire_value;
            // Clear only if no younger writer took the register
            if (retire_en && map_tag[retire_dest] == retire_tag)
                map_valid[retire_dest] <= 1'b0;
            // New mapping wins over a retire clear
            if (accept && in_dest != '0)
                map_valid[in_dest] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && in_dest != '0)
            map_tag[in_dest] <= rob_tail;
    end

endmodule

/* hw/rs_alu_slot.sv */
// Reservation-station slot with ALU
`timescale 1ns/100ps
`include "ooo_macros.svh"

module rs_alu_slot
    import ooo_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    // Allocation from dispatch
    input  logic     alloc,
    input  alu_op_e  alloc_op,
    input  word_t    alloc_v1,
    input  word_t    alloc_v2,
    input  logic     alloc_rdy1,
    input  logic     alloc_rdy2,
    input  rob_tag_t alloc_q1,
    input  rob_tag_t alloc_q2,
    input  rob_tag_t alloc_tag,
    // Result bus snoop
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    input  logic     grant,
    output logic     busy,
    output logic     done,
    output rob_tag_t result_tag,
    output word_t    result_value
);

    // Held operation
    alu_op_e  op_q;
    word_t    v1_q;
    word_t    v2_q;
    logic     rdy1_q;
    logic     rdy2_q;
    rob_tag_t q1_q;
    rob_tag_t q2_q;
    rob_tag_t tag_q;

    logic capture1;
    logic capture2;
    logic fire;

    function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a + b;  // ADD and ADDI
        endcase
    endfunction

    // Tag match on the bus
    assign capture1 = busy && !rdy1_q && cdb_valid && cdb_tag == q1_q;
    assign capture2 = busy && !rdy2_q && cdb_valid && cdb_tag == q2_q;

    // Both operands in hand, not yet computed
    assign fire = busy && rdy1_q && rdy2_q && !done;

    assign result_tag = tag_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (alloc) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (grant) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (fire) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            op_q   <= alloc_op;
            v1_q   <= alloc_v1;
            v2_q   <= alloc_v2;
            rdy1_q <= alloc_rdy1;
            rdy2_q <= alloc_rdy2;
            q1_q   <= alloc_q1;
            q2_q   <= alloc_q2;
            tag_q  <= alloc_tag;
        end else begin
            if (capture1) begin
                v1_q   <= cdb_value;
                rdy1_q <= 1'b1;
            end
            if (capture2) begin
                v2_q   <= cdb_value;
                rdy2_q <= 1'b1;
            end
            // Result held until grant
            if (fire)
                result_value <= alu(op_q, v1_q, v2_q);
        end
    end

endmodule

/* hw/cdb_arbiter.sv */
// Common data bus arbiter
`timescale 1ns/100ps
`include "ooo_macros.svh"

module cdb_arbiter
    import ooo_pkg::*;
(
    input  rs_mask_t slot_done,
    input  rob_tag_t slot_tag [`OOO_NUM_RS],
    input  word_t    slot_value [`OOO_NUM_RS],
    output rs_mask_t grant,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value
);

    //////////////////////////////////////////////////////////////////////
    // Fixed priority with slot 0 first
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        grant     = '0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_value = '0;
        for (int i = 0; i < `OOO_NUM_RS; i++) begin
            // First done slot takes the bus
            if (slot_done[i] && !cdb_valid) begin
                grant[i]  = 1'b1;
                cdb_valid = 1'b1;
                cdb_tag   = slot_tag[i];
                cdb_value = slot_value[i];
            end
        end
    end

endmodule

/* hw/reorder_buffer.sv */
// Reorder buffer with in-order retirement
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    // Allocation at the tail
    input  logic     alloc_en,
    input  areg_t    alloc_dest,
    output logic     rob_ready,
    output rob_tag_t tail,
    // Result bus
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    // Operand read ports
    input  rob_tag_t rd1_tag,
    input  rob_tag_t rd2_tag,
    output logic     rd1_complete,
    output word_t    rd1_value,
    output logic     rd2_complete,
    output word_t    rd2_value,
    // Retire write to dispatch
    output logic     retire_en,
    output areg_t    retire_dest,
    output rob_tag_t retire_tag,
    output word_t    retire_value,
    // Commit report
    output logic     commit_valid,
    output logic     commit_wr_en,
    output areg_t    commit_wr_idx,
    output word_t    commit_wr_data
);

    // Per-entry state
    logic [`OOO_ROB_DEPTH-1:0] ent_complete;
    areg_t                     ent_dest [`OOO_ROB_DEPTH];
    word_t                     ent_value [`OOO_ROB_DEPTH];

    rob_tag_t                head;
    logic [`OOO_ROB_TAG_W:0] count;
    logic [`OOO_ROB_TAG_W:0] count_next;

    //////////////////////////////////////////////////////////////////////
    // Retire and read ports
    //////////////////////////////////////////////////////////////////////

    // Head leaves as soon as its result is in
    assign retire_en    = (count != '0) && ent_complete[head];
    assign retire_dest  = ent_dest[head];
    assign retire_tag   = head;
    assign retire_value = ent_value[head];

    assign commit_valid   = retire_en;
    assign commit_wr_en   = retire_en && (retire_dest != '0);
    assign commit_wr_idx  = retire_dest;
    assign commit_wr_data = retire_value;

    assign rd1_complete = ent_complete[rd1_tag];
    assign rd1_value    = ent_value[rd1_tag];
    assign rd2_complete = ent_complete[rd2_tag];
    assign rd2_value    = ent_value[rd2_tag];

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        count_next = count;
        if (alloc_en && !retire_en)
            count_next = count + 1'b1;
        else if (!alloc_en && retire_en)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rob_ready <= 1'b0;
        end else begin
            if (alloc_en)
                tail <= tail + 1'b1;
            if (retire_en)
                head <= head + 1'b1;
            count     <= count_next;
            // Space for one more next cycle
            rob_ready <= count_next < `OOO_ROB_DEPTH;
        end
    end

    // Complete flags are cleared when an entry is reused
    always_ff @(posedge clock) begin
        if (reset) begin
            ent_complete <= '0;
        end else begin
            if (cdb_valid)
                ent_complete[cdb_tag] <= 1'b1;
            if (alloc_en)
                ent_complete[tail] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_en)
            ent_dest[tail] <= alloc_dest;
        if (cdb_valid)
            ent_value[cdb_tag] <= cdb_value;
    end

endmodule

/* hw/ooo_core.sv */
// Out-of-order execution core top
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core
    import ooo_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  alu_op_e in_op,
    input  areg_t   in_dest,
    input  areg_t   in_src1,
    input  areg_t   in_src2,
    input  word_t   in_imm,
    output logic    in_ready,
    output logic    commit_valid,
    output logic    commit_wr_en,
    output areg_t   commit_wr_idx,
    output word_t   commit_wr_data
);

    // Dispatch to slots
    rs_mask_t alloc_mask;
    alu_op_e  alloc_op;
    word_t    alloc_v1;
    word_t    alloc_v2;
    logic     alloc_rdy1;
    logic     alloc_rdy2;
    rob_tag_t alloc_q1;
    rob_tag_t alloc_q2;
    rob_tag_t alloc_tag;

    // Slot array
    rs_mask_t slot_busy;
    rs_mask_t slot_done;
    rob_tag_t slot_tag [`OOO_NUM_RS];
    word_t    slot_value [`OOO_NUM_RS];
    rs_mask_t grant;

    // Result bus
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;

    // Reorder buffer
    logic     rob_ready;
    rob_tag_t rob_tail;
    rob_tag_t rob_rd1_tag;
    rob_tag_t rob_rd2_tag;
    logic     rob_rd1_complete;
    word_t    rob_rd1_value;
    logic     rob_rd2_complete;
    word_t    rob_rd2_value;
    logic     rob_alloc_en;
    areg_t    rob_alloc_dest;
    logic     retire_en;
    areg_t    retire_dest;
    rob_tag_t retire_tag;
    word_t    retire_value;

    //////////////////////////////////////////////////////////////////////
    // Rename and dispatch
    //////////////////////////////////////////////////////////////////////

    rename_dispatch u_rename_dispatch (
        .clock            (clock),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_op            (in_op),
        .in_dest          (in_dest),
        .in_src1          (in_src1),
        .in_src2          (in_src2),
        .in_imm           (in_imm),
        .in_ready         (in_ready),
        .slot_busy        (slot_busy),
        .alloc_mask       (alloc_mask),
        .alloc_op         (alloc_op),
        .alloc_v1         (alloc_v1),
        .alloc_v2         (alloc_v2),
        .alloc_rdy1       (alloc_rdy1),
        .alloc_rdy2       (alloc_rdy2),
        .alloc_q1         (alloc_q1),
        .alloc_q2         (alloc_q2),
        .alloc_tag        (alloc_tag),
        .rob_ready        (rob_ready),
        .rob_tail         (rob_tail),
        .rob_rd1_tag      (rob_rd1_tag),
        .rob_rd2_tag      (rob_rd2_tag),
        .rob_rd1_complete (rob_rd1_complete),
        .rob_rd1_value    (rob_rd1_value),
        .rob_rd2_complete (rob_rd2_complete),
        .rob_rd2_value    (rob_rd2_value),
        .rob_alloc_en     (rob_alloc_en),
        .rob_alloc_dest   (rob_alloc_dest),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .retire_en        (retire_en),
        .retire_dest      (retire_dest),
        .retire_tag       (retire_tag),
        .retire_value     (retire_value)
    );

    //////////////////////////////////////////////////////////////////////
    // Slots and bus
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `OOO_NUM_RS; i++) begin : g_slot
        rs_alu_slot u_slot (
            .clock        (clock),
            .reset        (reset),
            .alloc        (alloc_mask[i]),
            .alloc_op     (alloc_op),
            .alloc_v1     (alloc_v1),
            .alloc_v2     (alloc_v2),
            .alloc_rdy1   (alloc_rdy1),
            .alloc_rdy2   (alloc_rdy2),
            .alloc_q1     (alloc_q1),
            .alloc_q2     (alloc_q2),
            .alloc_tag    (alloc_tag),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_value    (cdb_value),
            .grant        (grant[i]),
            .busy         (slot_busy[i]),
            .done         (slot_done[i]),
            .result_tag   (slot_tag[i]),
            .result_value (slot_value[i])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .slot_done  (slot_done),
        .slot_tag   (slot_tag),
        .slot_value (slot_value),
        .grant      (grant),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value)
    );

    // In-order retirement and commit port
    reorder_buffer u_reorder_buffer (
        .clock          (clock),
        .reset          (reset),
        .alloc_en       (rob_alloc_en),
        .alloc_dest     (rob_alloc_dest),
        .rob_ready      (rob_ready),
        .tail           (rob_tail),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .rd1_tag        (rob_rd1_tag),
        .rd2_tag        (rob_rd2_tag),
        .rd1_complete   (rob_rd1_complete),
        .rd1_value      (rob_rd1_value),
        .rd2_complete   (rob_rd2_complete),
        .rd2_value      (rob_rd2_value),
        .retire_en      (retire_en),
        .retire_dest    (retire_dest),
        .retire_tag     (retire_tag),
        .retire_value   (retire_value),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data)
    );

endmodule

/* bench/ooo_core_sva.sv */
// Core handshake and commit assertions
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core_sva
    import ooo_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     in_valid,
    input alu_op_e  in_op,
    input areg_t    in_dest,
    input areg_t    in_src1,
    input areg_t    in_src2,
    input word_t    in_imm,
    input logic     in_ready,
    input logic     commit_valid,
    input logic     commit_wr_en,
    input areg_t    commit_wr_idx,
    input rs_mask_t grant
);

    // Closed while reset holds after its first edge
    a_ready_in_reset: assert property (@(posedge clock)
        (reset && $past(reset)) |-> !in_ready)
        else $error("in_ready high during reset");

    // No write without a commit and none to r0
    a_commit_write: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> (commit_valid && commit_wr_idx != '0))
        else $error("commit_wr_en without commit_valid or with index 0");

    // At most one slot on the bus
    a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(grant))
        else $error("more than one bus grant");

    // Stalled op held by the source
    a_input_hold: assert property (@(posedge clock) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_op) && $stable(in_dest)
            && $stable(in_src1) && $stable(in_src2) && $stable(in_imm)))
        else $error("input op changed while stalled");

endmodule

bind ooo_core ooo_core_sva u_sva (
    .clock         (clock),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_dest       (in_dest),
    .in_src1       (in_src1),
    .in_src2       (in_src2),
    .in_imm        (in_imm),
    .in_ready      (in_ready),
    .commit_valid  (commit_valid),
    .commit_wr_en  (commit_wr_en),
    .commit_wr_idx (commit_wr_idx),
    .grant         (grant)
);

/* bench/ooo_core_tb.sv */
// Core testbench
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core_tb
    import ooo_pkg::*;
;

    //////////////////////////////////////////////////////////////////////
    // Run length
    //////////////////////////////////////////////////////////////////////

    localparam int N_SEED  = 8;
    localparam int N_CHAIN = 12;
    localparam int N_RAND  = 60;
    localparam int N_ZERO  = 6;
    localparam int TOTAL_OPS   = N_SEED + N_CHAIN + N_RAND + N_ZERO;
    // 12 cycles of 4 ns per op plus margin
    localparam int WATCHDOG_NS = TOTAL_OPS * 12 * 4 + 200;

    logic    clock;
    logic    reset;
    logic    in_valid;
    alu_op_e in_op;
    areg_t   in_dest;
    areg_t   in_src1;
    areg_t   in_src2;
    word_t   in_imm;
    logic    in_ready;
    logic    commit_valid;
    logic    commit_wr_en;
    areg_t   commit_wr_idx;
    word_t   commit_wr_data;

    // Model state in program order
    word_t  model_regs [`OOO_NUM_AREGS];
    areg_t  exp_dest [$];
    word_t  exp_data [$];
    areg_t  want_dest;
    word_t  want_data;
    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     accepted;
    int     committed;
    int     stalls;

    ooo_core u_dut (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_dest        (in_dest),
        .in_src1        (in_src1),
        .in_src2        (in_src2),
        .in_imm         (in_imm),
        .in_ready       (in_ready),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // Expected ALU result
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + b;
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send_op(input alu_op_e op, input areg_t dest, input areg_t src1,
                           input areg_t src2, input word_t imm);
        logic  got;
        word_t b;
        word_t expected;
        in_valid = 1'b1;
        in_op    = op;
        in_dest  = dest;
        in_src1  = src1;
        in_src2  = src2;
        in_imm   = imm;
        got      = 1'b0;
        // in_ready only moves on the edge
        while (!got) begin
            @(negedge clock);
            got = in_ready;
            if (!got)
                stalls++;
        end
        b        = (op == OP_ADDI) ? imm : model_regs[src2];
        expected = alu_ref(op, model_regs[src1], b);
        exp_dest.push_back(dest);
        exp_data.push_back(expected);
        if (dest != '0)
            model_regs[dest] = expected;
        accepted++;
        @(posedge clock);
        #1;
    endtask

    task automatic pause(input int cycles);
        in_valid = 1'b0;
        repeat (cycles) @(posedge clock);
        #1;
    endtask

    // Drain and report one line for the test
    task automatic finish_test(input string name, input int err_before);
        in_valid = 1'b0;
        while (exp_data.size() != 0)
            @(negedge clock);
        if (committed != accepted) begin
            $display("Commit count %0d does not match accepted count %0d", committed, accepted);
            errors++;
        end
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
        @(posedge clock);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Commit compare
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            committed++;
            if (exp_data.size() == 0) begin
                $display("Commit at %0t ns arrived with no op pending", $time);
                errors++;
            end else begin
                want_dest = exp_dest.pop_front();
                want_data = exp_data.pop_front();
                checks++;
                if (commit_wr_idx !== want_dest) begin
                    $display("** Error at %0t ns: commit index r%0d, expected r%0d",
                             $time, commit_wr_idx, want_dest);
                    errors++;
                end
                if (commit_wr_data !== want_data) begin
                    $display("** Error at %0t ns: commit data %h, expected %h",
                             $time, commit_wr_data, want_data);
                    errors++;
                end
                // Register 0 commits without a write
                if (commit_wr_en !== (want_dest != '0)) begin
                    $display("** Error at %0t ns: commit_wr_en %b for r%0d",
                             $time, commit_wr_en, want_dest);
                    errors++;
                end
            end
        end
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d ops still pending", WATCHDOG_NS, exp_data.size());
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    err_mark;
        int    stall_mark;
        int    op_idx;
        areg_t prev;
        areg_t dest;
        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        seed         = 74;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        accepted     = 0;
        committed    = 0;
        stalls       = 0;
        for (int i = 0; i < `OOO_NUM_AREGS; i++)
            model_regs[i] = '0;

        // Test 1 checks quiet outputs in and after reset
        err_mark = errors;
        repeat (8) begin
            @(posedge clock);
            #1;
            if (in_ready !== 1'b0 || commit_valid !== 1'b0 || commit_wr_en !== 1'b0) begin
                $display("** Error at %0t ns: handshake or commit active in reset", $time);
                errors++;
            end
        end
        reset = 1'b0;
        @(negedge clock);
        if (in_ready !== 1'b0 || commit_valid !== 1'b0 || commit_wr_en !== 1'b0) begin
            $display("** Error at %0t ns: handshake or commit active after reset", $time);
            errors++;
        end
        finish_test("reset", err_mark);

        // Test 2 seeds registers from r0
        err_mark = errors;
        for (int i = 1; i <= N_SEED; i++)
            send_op(OP_ADDI, areg_t'(i), '0, '0, $random(seed));
        finish_test("seed", err_mark);

        // Test 3 chains each op on the previous result
        err_mark = errors;
        prev     = areg_t'(1);
        for (int i = 0; i < N_CHAIN; i++) begin
            dest = areg_t'(10 + (i % 4));
            send_op((i % 2 == 0) ? OP_ADD : OP_SUB, dest, prev, areg_t'(1 + (i % 8)), '0);
            prev = dest;
            // Gap sets where the next op finds its operand
            case (i % 4)
                0: pause(1);  // on the bus at dispatch
                1: pause(2);  // complete in the reorder buffer
                3: pause(4);  // retired to the register file
                default: ;    // back to back, caught by the slot
            endcase
        end
        finish_test("chain", err_mark);

        // Test 4 sends a random mix with in_valid held high
        err_mark   = errors;
        stall_mark = stalls;
        for (int i = 0; i < N_RAND; i++) begin
            op_idx = int'($unsigned($random(seed)) % 6);
            send_op(alu_op_e'(op_idx[2:0]), areg_t'($random(seed) & 7),
                    areg_t'($random(seed) & 7), areg_t'($random(seed) & 7), $random(seed));
        end
        if (stalls == stall_mark) begin
            $display("in_ready never dropped during the random mix");
            errors++;
        end
        finish_test("random", err_mark);

        // Test 5 checks that writes to r0 are dropped
        err_mark = errors;
        send_op(OP_ADDI, '0, areg_t'(1), '0, 32'h0000_0055);
        send_op(OP_ADD, '0, areg_t'(2), areg_t'(3), '0);
        send_op(OP_ADD, areg_t'(4), '0, '0, '0);
        send_op(OP_XOR, areg_t'(5), '0, areg_t'(2), '0);
        send_op(OP_SUB, areg_t'(6), areg_t'(1), '0, '0);
        send_op(OP_OR, areg_t'(7), '0, '0, '0);
        finish_test("zero", err_mark);

        $display("tests %0d, failed %0d, commits checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hw/ooo_pkg.sv
hw/rename_dispatch.sv
hw/rs_alu_slot.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
bench/ooo_core_sva.sv
bench/ooo_core_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ooo_core_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Status comes from the search of the log
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
